// ==== build.f ====
+incdir+testbench
source/csr_pkg.sv
source/csr_request_decoder.sv
source/csr_queue.sv
source/csr_register_file.sv
source/csr_unit.sv
testbench/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
    --top-module csr_unit_tb -Mdir obj_dir -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim 2>&1) || {
    echo "$out"
    exit 1
}
echo "$out"
echo "$out" | grep -qx "Test OK"

// ==== testbench/csr_tb_model.svh ====
`ifndef csr_tb_model_svh
`define csr_tb_model_svh

// reference copy of the architectural CSR state, kept in request order
logic        model_mie;
logic        model_mpie;
logic [31:0] model_mtvec;
logic [31:0] model_mscratch;
logic [31:0] model_mepc;
logic [31:0] model_mcause;

// one step of a 32-bit xorshift generator, the caller keeps the state
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic model_reset();
    model_mie      = 1'b0;
    model_mpie     = 1'b0;
    model_mtvec    = tb_mtvec_reset;
    model_mscratch = '0;
    model_mepc     = '0;
    model_mcause   = '0;
endtask

// internal cause to the mcause exception code
function automatic logic [3:0] cause_code(input logic [2:0] cause);
    case (cause)
        3'd0:    return 4'd0;
        3'd1:    return 4'd2;
        3'd2:    return 4'd3;
        3'd3:    return 4'd4;
        3'd4:    return 4'd6;
        3'd5:    return 4'd11;
        default: return 4'd2;
    endcase
endfunction

// mstatus is built field by field: MPP = 11 at bits 12:11, MPIE at 7, MIE at 3
function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
        csr_mstatus:  return {19'd0, priv_machine, 3'd0, model_mpie, 3'd0, model_mie, 3'd0};
        csr_misa:     return misa_value;
        csr_mtvec:    return model_mtvec;
        csr_mscratch: return model_mscratch;
        csr_mepc:     return model_mepc;
        csr_mcause:   return model_mcause;
        default:      return '0;
    endcase
endfunction

// read-only and unknown addresses simply drop the write
function automatic void model_write(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
        csr_mstatus: begin
            model_mie  = value[3];
            model_mpie = value[7];
        end
        csr_mtvec:    model_mtvec    = value;
        csr_mscratch: model_mscratch = value;
        csr_mepc:     model_mepc     = value & 32'hFFFF_FFFE;
        csr_mcause:   model_mcause   = value;
        default: ;
    endcase
endfunction

// expected response as {rdata, redirect, pc}, the model state moves on
function automatic logic [64:0] expected_response(
    input csr_kind_e   kind,
    input logic [2:0]  funct3,
    input logic [11:0] addr,
    input logic [31:0] rs1,
    input logic [4:0]  zimm,
    input logic [2:0]  cause,
    input logic [31:0] pc
);
    logic [31:0] old_value;
    logic [31:0] operand;
    logic [31:0] target;
    old_value = model_read(addr);
    operand   = funct3[2] ? {27'd0, zimm} : rs1;
    if (kind == kind_exception) begin
        model_mpie   = model_mie;
        model_mie    = 1'b0;
        model_mepc   = pc & 32'hFFFF_FFFE;
        model_mcause = {28'd0, cause_code(cause)};
        return {32'd0, 1'b1, model_mtvec & 32'hFFFF_FFFC};
    end
    if (kind == kind_mret) begin
        target     = model_mepc & 32'hFFFF_FFFE;
        model_mie  = model_mpie;
        model_mpie = 1'b1;
        return {32'd0, 1'b1, target};
    end
    case (funct3[1:0])
        2'd1:    model_write(addr, operand);
        2'd2:    model_write(addr, old_value | operand);
        2'd3:    model_write(addr, old_value & ~operand);
        default: ;
    endcase
    return {old_value, 1'b0, 32'd0};
endfunction

`endif

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int          tb_queue_depth = 4;
    localparam logic [31:0] tb_mtvec_reset = 32'h8000_0103;
    localparam logic [31:0] rng_seed       = 32'd90263;
    localparam int          random_count   = 150;
    localparam int          accept_timeout = 200;
    localparam int          drain_timeout  = 2000;

    logic         clk_i;
    logic         rst_i;
    logic         req_valid_i;
    logic         req_ready_o;
    csr_kind_e    req_kind_i;
    logic [2:0]   req_funct3_i;
    logic [11:0]  req_addr_i;
    logic [31:0]  req_rs1_i;
    logic [4:0]   req_zimm_i;
    excep_cause_e req_cause_i;
    logic [31:0]  req_pc_i;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    logic [31:0]  rsp_rdata_o;
    logic         rsp_redirect_o;
    logic [31:0]  rsp_pc_o;

    // 0 keeps rsp_ready_i high, 1 randomizes it, 2 holds it low
    logic [1:0]   ready_mode;
    logic [31:0]  stim_state;
    logic [64:0]  expected_q[$];
    string        name_q[$];
    int           sent_count;
    int           received_count;

    `include "csr_tb_model.svh"

    csr_unit #(
        .queue_depth (tb_queue_depth),
        .mtvec_reset (tb_mtvec_reset)
    ) csr_unit_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_kind_i     (req_kind_i),
        .req_funct3_i   (req_funct3_i),
        .req_addr_i     (req_addr_i),
        .req_rs1_i      (req_rs1_i),
        .req_zimm_i     (req_zimm_i),
        .req_cause_i    (req_cause_i),
        .req_pc_i       (req_pc_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_rdata_o    (rsp_rdata_o),
        .rsp_redirect_o (rsp_redirect_o),
        .rsp_pc_o       (rsp_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // failure reporting and the compare check
    // ------------------------------------------------------------
    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // ------------------------------------------------------------
    // request driver tasks that each return 1 ns after a rising edge
    // ------------------------------------------------------------
    task automatic send_request(input csr_kind_e kind, input logic [2:0] funct3,
                                input logic [11:0] addr, input logic [31:0] rs1,
                                input logic [4:0] zimm, input logic [2:0] cause,
                                input logic [31:0] pc, input string name);
        int   waited;
        logic ready_seen;
        waited       = 0;
        ready_seen   = 1'b0;
        req_valid_i  = 1'b1;
        req_kind_i   = kind;
        req_funct3_i = funct3;
        req_addr_i   = addr;
        req_rs1_i    = rs1;
        req_zimm_i   = zimm;
        req_cause_i  = excep_cause_e'(cause);
        req_pc_i     = pc;
        // ready only moves at rising edges, so the falling edge sees a settled value
        while (!ready_seen) begin
            @(negedge clk_i);
            ready_seen = req_ready_o;
            @(posedge clk_i);
            #1;
            waited++;
            if (!ready_seen && waited > accept_timeout) begin
                $display("ERROR: request '%s' was not accepted in time", name);
                stop_on_failure();
            end
        end
        req_valid_i = 1'b0;
        expected_q.push_back(expected_response(kind, funct3, addr, rs1, zimm, cause, pc));
        name_q.push_back(name);
        sent_count++;
    endtask

    // csrrs with rs1 = x0 is the plain read
    task automatic read_csr(input logic [11:0] addr, input string name);
        send_request(kind_csr, 3'd2, addr, '0, '0, '0, '0, name);
    endtask

    task automatic send_random_csr(input logic [11:0] addr_table [16], input string name);
        logic [31:0] r;
        stim_state = xorshift32(stim_state);
        r          = stim_state;
        stim_state = xorshift32(stim_state);
        send_request(kind_csr, r[2:0], addr_table[r[6:3]], stim_state, r[11:7], '0, '0, name);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (received_count != sent_count) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > drain_timeout) begin
                $display("ERROR: %0d responses never arrived", sent_count - received_count);
                stop_on_failure();
            end
        end
    endtask

    // ------------------------------------------------------------
    // response side with the ready pattern and the compare process
    // ------------------------------------------------------------
    initial begin : drive_rsp_ready
        logic [1:0]  mode_now;
        logic [31:0] ready_state;
        ready_state = ~rng_seed;
        rsp_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            mode_now = ready_mode;
            #1;
            ready_state = xorshift32(ready_state);
            case (mode_now)
                2'd0:    rsp_ready_i = 1'b1;
                2'd1:    rsp_ready_i = (ready_state[1:0] != 2'd0);
                default: rsp_ready_i = 1'b0;
            endcase
        end
    end

    // the handshake completes at the next rising edge and the data is stable here
    initial begin : compare_responses
        logic [64:0] expected;
        string       name;
        forever begin
            @(negedge clk_i);
            if (rsp_valid_o && rsp_ready_i) begin
                if (expected_q.size() == 0) begin
                    $display("ERROR: a response arrived with no request outstanding");
                    stop_on_failure();
                end
                expected = expected_q.pop_front();
                name     = name_q.pop_front();
                check_value({name, " rdata"}, expected[64:33], rsp_rdata_o);
                check_value({name, " redirect"}, {31'd0, expected[32]}, {31'd0, rsp_redirect_o});
                // the pc field only carries meaning on a redirect
                if (expected[32]) begin
                    check_value({name, " pc"}, expected[31:0], rsp_pc_o);
                end
                received_count++;
            end
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : run_test
        logic [11:0] addr_table [16];
        int          i;
        int          attempts;
        logic        stalled;
        req_valid_i    = 1'b0;
        req_kind_i     = kind_csr;
        req_funct3_i   = '0;
        req_addr_i     = '0;
        req_rs1_i      = '0;
        req_zimm_i     = '0;
        req_cause_i    = cause_instr_misaligned;
        req_pc_i       = '0;
        rst_i          = 1'b0;
        ready_mode     = 2'd0;
        stim_state     = rng_seed;
        sent_count     = 0;
        received_count = 0;
        model_reset();
        // writable, read-only and two unknown addresses
        addr_table = '{csr_mstatus, csr_misa, csr_mtvec, csr_mscratch, csr_mepc, csr_mcause,
                       csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_mconfigptr,
                       csr_mstatush, csr_mtval, csr_mtinst, 12'h7C0, 12'h345};
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        @(posedge clk_i);
        #1;

        read_csr(csr_misa, "reset misa");
        read_csr(csr_mtvec, "reset mtvec");
        read_csr(csr_mstatus, "reset mstatus");
        read_csr(csr_mhartid, "reset mhartid");
        read_csr(12'h7C0, "reset unknown address");

        // every cause is raised with MIE set on even passes and clear on odd ones
        for (i = 0; i < 8; i++) begin
            send_request(kind_csr, (i % 2 == 0) ? 3'd6 : 3'd7, csr_mstatus, '0, 5'd8, '0, '0,
                         $sformatf("mie setup %0d", i));
            stim_state = xorshift32(stim_state);
            send_request(kind_exception, '0, '0, '0, '0, i[2:0], stim_state,
                         $sformatf("exception cause %0d", i));
            read_csr(csr_mcause, $sformatf("mcause after cause %0d", i));
            read_csr(csr_mepc, $sformatf("mepc after cause %0d", i));
            read_csr(csr_mstatus, $sformatf("mstatus after cause %0d", i));
            send_request(kind_mret, '0, '0, '0, '0, '0, '0, $sformatf("mret %0d", i));
            read_csr(csr_mstatus, $sformatf("mstatus after mret %0d", i));
        end

        ready_mode = 2'd1;
        for (i = 0; i < random_count; i++) begin
            send_random_csr(addr_table, $sformatf("random csr %0d", i));
        end

        // with responses held back both queues fill and the request side stalls
        ready_mode = 2'd2;
        attempts   = 0;
        stalled    = 1'b0;
        while (!stalled) begin
            @(negedge clk_i);
            stalled = !req_ready_o;
            @(posedge clk_i);
            #1;
            if (!stalled) begin
                attempts++;
                if (attempts > 4 * tb_queue_depth + 8) begin
                    $display("ERROR: req_ready_o stayed high while responses were held back");
                    stop_on_failure();
                end
                send_random_csr(addr_table, $sformatf("backpressure fill %0d", attempts));
            end
        end
        ready_mode = 2'd1;
        wait_for_drain();
        for (i = 0; i < 40; i++) begin
            send_random_csr(addr_table, $sformatf("random ready burst %0d", i));
        end

        ready_mode = 2'd0;
        wait_for_drain();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter int                       queue_depth = 4,
    parameter logic [csr_pkg::xlen-1:0] mtvec_reset = 32'h0000_0100
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    // request side
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  csr_pkg::csr_kind_e             req_kind_i,
    input  logic [2:0]                     req_funct3_i,
    input  logic [csr_pkg::csr_addr_w-1:0] req_addr_i,
    input  logic [csr_pkg::xlen-1:0]       req_rs1_i,
    input  logic [4:0]                     req_zimm_i,
    input  csr_pkg::excep_cause_e          req_cause_i,
    input  logic [csr_pkg::xlen-1:0]       req_pc_i,
    // response side
    output logic                           rsp_valid_o,
    input  logic                           rsp_ready_i,
    output logic [csr_pkg::xlen-1:0]       rsp_rdata_o,
    output logic                           rsp_redirect_o,
    output logic [csr_pkg::xlen-1:0]       rsp_pc_o
);
    import csr_pkg::*;

    // decoder to request queue
    logic     dec_valid;
    logic     dec_ready;
    csr_req_t dec_req;

    // request queue to register file
    logic     rq_valid;
    logic     rq_ready;
    csr_req_t rq_data;

    // register file to response queue
    logic     rf_valid;
    logic     rf_ready;
    csr_rsp_t rf_rsp;

    // response queue to the port
    csr_rsp_t rsp_data;

    // ------------------------------------------------------------
    // request path
    // ------------------------------------------------------------
    csr_request_decoder decoder_i (
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_kind_i   (req_kind_i),
        .req_funct3_i (req_funct3_i),
        .req_addr_i   (req_addr_i),
        .req_rs1_i    (req_rs1_i),
        .req_zimm_i   (req_zimm_i),
        .req_cause_i  (req_cause_i),
        .req_pc_i     (req_pc_i),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready),
        .dec_req_o    (dec_req)
    );

    csr_queue #(
        .queue_depth (queue_depth),
        .payload_t   (csr_req_t)
    ) req_queue_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_req),
        .out_valid_o (rq_valid),
        .out_ready_i (rq_ready),
        .out_data_o  (rq_data)
    );

    // ------------------------------------------------------------
    // execute and response path
    // ------------------------------------------------------------
    csr_register_file #(
        .mtvec_reset (mtvec_reset)
    ) register_file_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (rq_valid),
        .req_ready_o (rq_ready),
        .req_i       (rq_data),
        .rsp_valid_o (rf_valid),
        .rsp_ready_i (rf_ready),
        .rsp_o       (rf_rsp)
    );

    csr_queue #(
        .queue_depth (queue_depth),
        .payload_t   (csr_rsp_t)
    ) rsp_queue_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (rf_valid),
        .in_ready_o  (rf_ready),
        .in_data_i   (rf_rsp),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i),
        .out_data_o  (rsp_data)
    );

    // response record out to loose ports
    assign rsp_rdata_o    = rsp_data.rdata;
    assign rsp_redirect_o = rsp_data.redirect;
    assign rsp_pc_o       = rsp_data.pc;

endmodule

// ==== source/csr_register_file.sv ====
`timescale 1ns/1ps

module csr_register_file #(
    parameter logic [csr_pkg::xlen-1:0] mtvec_reset = 32'h0000_0100
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  csr_pkg::csr_req_t req_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output csr_pkg::csr_rsp_t rsp_o
);
    import csr_pkg::*;

    // ------------------------------------------------------------
    // architectural state
    // ------------------------------------------------------------
    // only MIE and MPIE of mstatus are kept as flops
    logic            mie_r, mie_ns;
    logic            mpie_r, mpie_ns;
    logic [xlen-1:0] mtvec_r, mtvec_ns;
    logic [xlen-1:0] mscratch_r, mscratch_ns;
    logic [xlen-1:0] mepc_r, mepc_ns;
    logic [xlen-1:0] mcause_r, mcause_ns;

    logic [xlen-1:0] mstatus_view;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;
    logic            fire;

    // one request is consumed per cycle, and only when its response
    // can be pushed in the same cycle
    assign req_ready_o = rsp_ready_i;
    assign rsp_valid_o = req_valid_i;
    assign fire        = req_valid_i & rsp_ready_i;

    // mstatus as software sees it with MPP always reading as machine mode
    always_comb begin
        mstatus_view = '0;
        mstatus_view[mstatus_mpp_lsb +: 2] = priv_machine;
        mstatus_view[mstatus_mpie_bit]     = mpie_r;
        mstatus_view[mstatus_mie_bit]      = mie_r;
    end

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    always_comb begin
        case (req_i.addr)
            csr_mstatus:  old_value = mstatus_view;
            csr_misa:     old_value = misa_value;
            csr_mtvec:    old_value = mtvec_r;
            csr_mscratch: old_value = mscratch_r;
            csr_mepc:     old_value = mepc_r;
            csr_mcause:   old_value = mcause_r;
            // the ID registers, mstatush, mtval, mtinst and unknown
            // addresses all read zero
            default:      old_value = '0;
        endcase
    end

    // value the CSR instruction would leave behind
    always_comb begin
        case (req_i.wop)
            wop_write: new_value = req_i.operand;
            wop_set:   new_value = old_value | req_i.operand;
            wop_clear: new_value = old_value & ~req_i.operand;
            default:   new_value = old_value;
        endcase
    end

    // ------------------------------------------------------------
    // next state and response
    // ------------------------------------------------------------
    always_comb begin
        mie_ns      = mie_r;
        mpie_ns     = mpie_r;
        mtvec_ns    = mtvec_r;
        mscratch_ns = mscratch_r;
        mepc_ns     = mepc_r;
        mcause_ns   = mcause_r;

        rsp_o.rdata    = '0;
        rsp_o.redirect = 1'b0;
        rsp_o.pc       = '0;

        case (req_i.kind)
            kind_csr: begin
                rsp_o.rdata = old_value;
                // read-only and unknown addresses fall through untouched
                if (req_i.wop != wop_none) begin
                    case (req_i.addr)
                        csr_mstatus: begin
                            mie_ns  = new_value[mstatus_mie_bit];
                            mpie_ns = new_value[mstatus_mpie_bit];
                        end
                        csr_mtvec:    mtvec_ns    = new_value;
                        csr_mscratch: mscratch_ns = new_value;
                        // with the C extension only bit 0 of mepc is forced low
                        csr_mepc:     mepc_ns     = {new_value[xlen-1:1], 1'b0};
                        csr_mcause:   mcause_ns   = new_value;
                        default: ;
                    endcase
                end
            end
            kind_exception: begin
                mpie_ns   = mie_r;
                mie_ns    = 1'b0;
                mepc_ns   = {req_i.pc[xlen-1:1], 1'b0};
                // synchronous exceptions only, so the interrupt bit stays 0
                mcause_ns = {{(xlen-4){1'b0}}, req_i.code};
                // in direct mode the handler starts at the base address
                rsp_o.redirect = 1'b1;
                rsp_o.pc       = {mtvec_r[xlen-1:2], 2'b00};
            end
            kind_mret: begin
                mie_ns  = mpie_r;
                mpie_ns = 1'b1;
                // bit 0 of mepc is already clear on every write path
                rsp_o.redirect = 1'b1;
                rsp_o.pc       = mepc_r;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // state registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            mie_r      <= 1'b0;
            mpie_r     <= 1'b0;
            mtvec_r    <= mtvec_reset;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_r   <= '0;
        end else if (fire) begin
            mie_r      <= mie_ns;
            mpie_r     <= mpie_ns;
            mtvec_r    <= mtvec_ns;
            mscratch_r <= mscratch_ns;
            mepc_r     <= mepc_ns;
            mcause_r   <= mcause_ns;
        end
    end

endmodule

// ==== source/csr_queue.sv ====
`timescale 1ns/1ps

module csr_queue #(
    parameter int  queue_depth = 4,
    parameter type payload_t   = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);
    localparam int ptr_w   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_w = $clog2(queue_depth + 1);

    payload_t           storage [queue_depth];
    logic [ptr_w-1:0]   wr_ptr_r;
    logic [ptr_w-1:0]   rd_ptr_r;
    logic [count_w-1:0] count_r;
    logic               push;
    logic               pop;

    // wraps by compare so that depths other than a power of two work
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // both flags come from the registered count, so there is no path
    // from one side of the queue to the other
    assign in_ready_o  = (count_r != count_w'(queue_depth));
    assign out_valid_o = (count_r != '0);
    assign out_data_o  = storage[rd_ptr_r];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            storage[wr_ptr_r] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (pop) begin
                rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            // a simultaneous push and pop leaves the count as it is
            if (push && !pop) begin
                count_r <= count_r + 1'b1;
            end else if (pop && !push) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

endmodule

// ==== source/csr_request_decoder.sv ====
`timescale 1ns/1ps

module csr_request_decoder (
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  csr_pkg::csr_kind_e            req_kind_i,
    input  logic [2:0]                    req_funct3_i,
    input  logic [csr_pkg::csr_addr_w-1:0] req_addr_i,
    input  logic [csr_pkg::xlen-1:0]      req_rs1_i,
    input  logic [4:0]                    req_zimm_i,
    input  csr_pkg::excep_cause_e         req_cause_i,
    input  logic [csr_pkg::xlen-1:0]      req_pc_i,
    output logic                          dec_valid_o,
    input  logic                          dec_ready_i,
    output csr_pkg::csr_req_t             dec_req_o
);
    import csr_pkg::*;

    csr_wop_e   wop;
    logic [3:0] code;

    // the decoder adds no latency, the handshake goes straight to the queue
    assign dec_valid_o = req_valid_i;
    assign req_ready_o = dec_ready_i;

    // ------------------------------------------------------------
    // funct3 decode
    // ------------------------------------------------------------
    // the low two bits pick the operation, bit 2 only picks the operand
    always_comb begin
        case (req_funct3_i[1:0])
            2'b01:   wop = wop_write;
            2'b10:   wop = wop_set;
            2'b11:   wop = wop_clear;
            default: wop = wop_none;
        endcase
    end

    // ------------------------------------------------------------
    // exception cause to mcause code
    // ------------------------------------------------------------
    // codes follow the privileged spec table for synchronous exceptions
    always_comb begin
        case (req_cause_i)
            cause_instr_misaligned: code = 4'd0;
            cause_illegal_instr:    code = 4'd2;
            cause_breakpoint:       code = 4'd3;
            cause_load_misaligned:  code = 4'd4;
            cause_store_misaligned: code = 4'd6;
            cause_env_call:         code = 4'd11;
            // the two spare encodings are reported as illegal instruction
            default:                code = 4'd2;
        endcase
    end

    // ------------------------------------------------------------
    // request record
    // ------------------------------------------------------------
    always_comb begin
        dec_req_o.kind = req_kind_i;
        // traps and mret never write through the CSR path
        dec_req_o.wop  = (req_kind_i == kind_csr) ? wop : wop_none;
        dec_req_o.addr = req_addr_i;
        // immediate forms zero-extend the 5-bit uimm field
        if (req_funct3_i[2]) begin
            dec_req_o.operand = {{(xlen-5){1'b0}}, req_zimm_i};
        end else begin
            dec_req_o.operand = req_rs1_i;
        end
        dec_req_o.code = code;
        dec_req_o.pc   = req_pc_i;
    end

endmodule

// ==== source/csr_pkg.sv ====
package csr_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    // ------------------------------------------------------------
    // machine-mode CSR addresses
    // ------------------------------------------------------------
    // information registers, all read-only zero in this core
    localparam logic [csr_addr_w-1:0] csr_mvendorid  = 12'hF11;
    localparam logic [csr_addr_w-1:0] csr_marchid    = 12'hF12;
    localparam logic [csr_addr_w-1:0] csr_mimpid     = 12'hF13;
    localparam logic [csr_addr_w-1:0] csr_mhartid    = 12'hF14;
    localparam logic [csr_addr_w-1:0] csr_mconfigptr = 12'hF15;

    // trap setup
    localparam logic [csr_addr_w-1:0] csr_mstatus    = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_misa       = 12'h301;
    localparam logic [csr_addr_w-1:0] csr_mtvec      = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mstatush   = 12'h310;

    // trap handling
    localparam logic [csr_addr_w-1:0] csr_mscratch   = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_mepc       = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause     = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mtval      = 12'h343;
    localparam logic [csr_addr_w-1:0] csr_mtinst     = 12'h34A;

    // mstatus fields that exist here, MPP is hardwired to machine mode
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;

    localparam logic [1:0] priv_machine = 2'b11;

    // MXL = 1 for RV32, with the I, M and C extension bits set
    localparam logic [xlen-1:0] misa_value = 32'h4000_1104;

    // ------------------------------------------------------------
    // request kinds and write operations
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        kind_csr,
        kind_exception,
        kind_mret
    } csr_kind_e;

    typedef enum logic [1:0] {
        wop_none,
        wop_write,
        wop_set,
        wop_clear
    } csr_wop_e;

    // internal exception causes as the pipeline reports them
    typedef enum logic [2:0] {
        cause_instr_misaligned = 3'd0,
        cause_illegal_instr    = 3'd1,
        cause_breakpoint       = 3'd2,
        cause_load_misaligned  = 3'd3,
        cause_store_misaligned = 3'd4,
        cause_env_call         = 3'd5
    } excep_cause_e;

    // ------------------------------------------------------------
    // queue payloads
    // ------------------------------------------------------------
    typedef struct packed {
        csr_kind_e             kind;
        csr_wop_e              wop;
        logic [csr_addr_w-1:0] addr;
        logic [xlen-1:0]       operand;
        logic [3:0]            code;
        logic [xlen-1:0]       pc;
    } csr_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            redirect;
        logic [xlen-1:0] pc;
    } csr_rsp_t;

endpackage
